// File: verilog/rv_decode_consts.svh
`ifndef RV_DECODE_CONSTS_SVH
`define RV_DECODE_CONSTS_SVH

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------
`define XLEN          64
`define NUM_REGS      32
`define REG_ADDR_W    5
`define ALU_OP_W      4
`define IMM_SEL_W     6        // One-hot I, S, B, J, U, zimm.
`define RD_SEL_W      2

`define RD_SEL_ALU    2'd0
`define RD_SEL_LINK   2'd1     // pc + 4.
`define RD_SEL_IMM    2'd2
`define RD_SEL_CSR    2'd3

// ------------------------------------------------------------
// Major opcodes and fixed system words
// ------------------------------------------------------------
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_ALU_I     7'b0010011
`define OPC_ALU_R     7'b0110011
`define OPC_ALU_IW    7'b0011011
`define OPC_ALU_W     7'b0111011
`define OPC_SYSTEM    7'b1110011

`define INST_ECALL    32'h0000_0073
`define INST_EBREAK   32'h0010_0073
`define INST_MRET     32'h3020_0073
`define INST_FENCE_I  32'h0000_100f

`endif

// File: verilog/rv_decode_pkg.sv
package rv_decode_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;     // Also the CSR address.
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        logic [31:0] word;
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        b_fmt_t      b;
        u_fmt_t      u;
        j_fmt_t      j;
    } inst_u;

endpackage

// File: verilog/opcode_decoder.sv
`timescale 1ns/1ns
`include "rv_decode_consts.svh"

module opcode_decoder
    import rv_decode_pkg::*;
(
    input  inst_u                  inst_i,
    output logic [`IMM_SEL_W-1:0]  imm_sel_o,
    output logic [`ALU_OP_W-1:0]   alu_op_o,
    output logic [`RD_SEL_W-1:0]   rd_sel_o,
    output logic                   alu_sub_o,
    output logic                   alu_sra_o,
    output logic                   alu_in1_pc_o,
    output logic                   alu_in2_imm_o,
    output logic                   rd_write_o,
    output logic                   is_branch_o,
    output logic                   is_jal_o,
    output logic                   is_jalr_o,
    output logic                   is_load_o,
    output logic                   is_store_o,
    output logic                   word_op_o,
    output logic                   csr_op_o,
    output logic                   csr_write_o,
    output logic                   ecall_o,
    output logic                   ebreak_o,
    output logic                   mret_o,
    output logic                   fence_i_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       lui, auipc, jal, jalr, branch, load, store;
    logic       alu_i, alu_r, alu_iw, alu_w, alu_any, csr;
    logic       csrrw, csrrs, csrrc, csr_read;

    assign opcode = inst_i.r.opcode;
    assign funct3 = inst_i.r.funct3;

    // ------------------------------------------------------------
    // Instruction class
    // ------------------------------------------------------------
    assign lui     = (opcode == `OPC_LUI);
    assign auipc   = (opcode == `OPC_AUIPC);
    assign jal     = (opcode == `OPC_JAL);
    assign jalr    = (opcode == `OPC_JALR);
    assign branch  = (opcode == `OPC_BRANCH);
    assign load    = (opcode == `OPC_LOAD);
    assign store   = (opcode == `OPC_STORE);
    assign alu_i   = (opcode == `OPC_ALU_I);
    assign alu_r   = (opcode == `OPC_ALU_R);
    assign alu_iw  = (opcode == `OPC_ALU_IW);
    assign alu_w   = (opcode == `OPC_ALU_W);
    assign alu_any = alu_i || alu_r || alu_iw || alu_w;
    assign csr     = (opcode == `OPC_SYSTEM) && (funct3 != 3'b000);

    assign ecall_o   = (inst_i.word == `INST_ECALL);
    assign ebreak_o  = (inst_i.word == `INST_EBREAK);
    assign mret_o    = (inst_i.word == `INST_MRET);
    assign fence_i_o = (inst_i.word == `INST_FENCE_I);

    // ------------------------------------------------------------
    // ALU control
    // ------------------------------------------------------------
    always_comb begin
        if (alu_r || alu_w) begin
            alu_op_o = {inst_i.r.funct7[0], funct3};
        end else if (alu_i || alu_iw) begin
            alu_op_o = {1'b0, funct3};
        end else begin
            alu_op_o = '0;
        end
    end

    assign alu_sub_o = (alu_r || alu_w) && (funct3 == 3'b000) &&
                       (inst_i.r.funct7 == 7'b0100000);
    assign alu_sra_o = alu_any && (funct3 == 3'b101) &&
                       (inst_i.r.funct7[6:1] == 6'b010000); // Bit 0 is shamt[5] on srai.

    assign alu_in1_pc_o  = auipc || jal || branch;
    assign alu_in2_imm_o = alu_i || alu_iw || auipc || jal || jalr || branch;

    // I, S, B, J, U, zimm from bit 0 up.
    assign imm_sel_o = {csr && funct3[2], lui || auipc, jal, branch, store,
                        alu_i || alu_iw || load || jalr};

    // ------------------------------------------------------------
    // Destination and CSR
    // ------------------------------------------------------------
    assign csrrw = csr && (funct3[1:0] == 2'b01);
    assign csrrs = csr && (funct3[1:0] == 2'b10);
    assign csrrc = csr && (funct3[1:0] == 2'b11);

    assign csr_read    = csrrs || csrrc || (csrrw && (inst_i.r.rd != 5'd0));
    assign csr_write_o = csrrw || ((csrrs || csrrc) && (inst_i.r.rs1 != 5'd0));
    assign csr_op_o    = csr;

    always_comb begin
        if (alu_any || auipc) begin
            rd_sel_o = `RD_SEL_ALU;
        end else if (lui) begin
            rd_sel_o = `RD_SEL_IMM;
        end else if (jal || jalr) begin
            rd_sel_o = `RD_SEL_LINK;
        end else if (csr) begin
            rd_sel_o = `RD_SEL_CSR;
        end else begin
            rd_sel_o = `RD_SEL_ALU;
        end
    end

    assign rd_write_o = alu_any || load || lui || auipc || jal || jalr || csr_read;

    assign is_branch_o = branch;
    assign is_jal_o    = jal;
    assign is_jalr_o   = jalr;
    assign is_load_o   = load;
    assign is_store_o  = store;
    assign word_op_o   = alu_iw || alu_w;

    // Class and system decodes never overlap.
    a_one_class: assert final ($onehot0({lui, auipc, jal, jalr, branch, load, store,
                                         alu_i, alu_r, alu_iw, alu_w, csr,
                                         ecall_o, ebreak_o, mret_o, fence_i_o}))
        else $error("opcode_decoder: more than one class decoded");

endmodule

// File: verilog/imm_gen.sv
`timescale 1ns/1ns
`include "rv_decode_consts.svh"

module imm_gen
    import rv_decode_pkg::*;
(
    input  inst_u                  inst_i,
    input  logic [`IMM_SEL_W-1:0]  imm_sel_i,
    output logic [`XLEN-1:0]       imm_o
);

    logic [`XLEN-1:0] ext_i;
    logic [`XLEN-1:0] ext_s;
    logic [`XLEN-1:0] ext_b;
    logic [`XLEN-1:0] ext_j;
    logic [`XLEN-1:0] ext_u;
    logic [`XLEN-1:0] ext_zimm;

    assign ext_i = {{(`XLEN-12){inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0};
    assign ext_s = {{(`XLEN-12){inst_i.s.imm_11_5[6]}}, inst_i.s.imm_11_5,
                    inst_i.s.imm_4_0};
    assign ext_b = {{(`XLEN-13){inst_i.b.imm_12}}, inst_i.b.imm_12, inst_i.b.imm_11,
                    inst_i.b.imm_10_5, inst_i.b.imm_4_1, 1'b0};
    assign ext_j = {{(`XLEN-21){inst_i.j.imm_20}}, inst_i.j.imm_20, inst_i.j.imm_19_12,
                    inst_i.j.imm_11, inst_i.j.imm_10_1, 1'b0};
    assign ext_u = {{(`XLEN-32){inst_i.u.imm_31_12[19]}}, inst_i.u.imm_31_12, 12'b0};
    assign ext_zimm = {{(`XLEN-5){1'b0}}, inst_i.r.rs1};   // Zero-extended, unlike the rest.

    always_comb begin
        case (imm_sel_i)
            6'b000001: imm_o = ext_i;
            6'b000010: imm_o = ext_s;
            6'b000100: imm_o = ext_b;
            6'b001000: imm_o = ext_j;
            6'b010000: imm_o = ext_u;
            6'b100000: imm_o = ext_zimm;
            default:   imm_o = '0;
        endcase
    end

    // The decoder must never request two formats at once.
    a_sel_onehot: assert final ($onehot0(imm_sel_i))
        else $error("imm_gen: immediate select not one-hot");

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ns
`include "rv_decode_consts.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`REG_ADDR_W-1:0]  rs1_i,
    input  logic [`REG_ADDR_W-1:0]  rs2_i,
    input  logic [`REG_ADDR_W-1:0]  wb_rd_i,
    input  logic                    wb_write_i,
    input  logic [`XLEN-1:0]        wb_data_i,
    output logic [`XLEN-1:0]        rs1_data_o,
    output logic [`XLEN-1:0]        rs2_data_o
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             rs1_hit;
    logic             rs2_hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write_i) begin
            regs[wb_rd_i] <= (wb_rd_i == '0) ? '0 : wb_data_i;   // x0 stays zero.
        end
    end

    // Bypass a same-cycle write-back, never onto x0.
    assign rs1_hit = wb_write_i && (wb_rd_i == rs1_i) && (rs1_i != '0);
    assign rs2_hit = wb_write_i && (wb_rd_i == rs2_i) && (rs2_i != '0);

    assign rs1_data_o = rs1_hit ? wb_data_i : regs[rs1_i];
    assign rs2_data_o = rs2_hit ? wb_data_i : regs[rs2_i];

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    a_x0_rs1: assert property (@(posedge clk) disable iff (!rst_n)
                               (rs1_i == '0) |-> (rs1_data_o == '0))
        else $error("reg_file: x0 read nonzero on rs1");

    a_x0_rs2: assert property (@(posedge clk) disable iff (!rst_n)
                               (rs2_i == '0) |-> (rs2_data_o == '0))
        else $error("reg_file: x0 read nonzero on rs2");

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ns
`include "rv_decode_consts.svh"

module decode_stage
    import rv_decode_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             inst_i,
    input  logic [`XLEN-1:0]        pc_i,
    input  logic                    inst_valid_i,
    input  logic                    ready_i,
    input  logic                    flush_i,
    input  logic                    wb_write_i,
    input  logic [`REG_ADDR_W-1:0]  wb_rd_i,
    input  logic [`XLEN-1:0]        wb_data_i,
    output logic                    ready_o,
    output logic                    valid_o,
    output logic [`XLEN-1:0]        pc_o,
    output logic [`XLEN-1:0]        rs1_data_o,
    output logic [`XLEN-1:0]        rs2_data_o,
    output logic [`XLEN-1:0]        imm_o,
    output logic [`REG_ADDR_W-1:0]  rd_o,
    output logic                    rd_write_o,
    output logic [`RD_SEL_W-1:0]    rd_sel_o,
    output logic [`ALU_OP_W-1:0]    alu_op_o,
    output logic                    alu_sub_o,
    output logic                    alu_sra_o,
    output logic                    alu_in1_pc_o,
    output logic                    alu_in2_imm_o,
    output logic                    is_branch_o,
    output logic                    is_jal_o,
    output logic                    is_jalr_o,
    output logic                    is_load_o,
    output logic                    is_store_o,
    output logic                    word_op_o,
    output logic [2:0]              funct3_o,
    output logic                    csr_op_o,
    output logic [11:0]             csr_addr_o,
    output logic                    csr_write_o,
    output logic                    ecall_o,
    output logic                    ebreak_o,
    output logic                    mret_o,
    output logic                    fence_i_o
);

    inst_u                  inst;
    logic [`IMM_SEL_W-1:0]  imm_sel;
    logic [`XLEN-1:0]       imm, rs1_data, rs2_data;
    logic [`ALU_OP_W-1:0]   alu_op;
    logic [`RD_SEL_W-1:0]   rd_sel;
    logic alu_sub, alu_sra, alu_in1_pc, alu_in2_imm, rd_write;
    logic is_branch, is_jal, is_jalr, is_load, is_store, word_op;
    logic csr_op, csr_write, ecall, ebreak, mret, fence_i;

    assign inst    = inst_i;
    assign ready_o = ready_i;   // No internal stall source.

    opcode_decoder u_decoder (
        .inst_i(inst), .imm_sel_o(imm_sel), .alu_op_o(alu_op), .rd_sel_o(rd_sel),
        .alu_sub_o(alu_sub), .alu_sra_o(alu_sra), .alu_in1_pc_o(alu_in1_pc),
        .alu_in2_imm_o(alu_in2_imm), .rd_write_o(rd_write), .is_branch_o(is_branch),
        .is_jal_o(is_jal), .is_jalr_o(is_jalr), .is_load_o(is_load),
        .is_store_o(is_store), .word_op_o(word_op), .csr_op_o(csr_op),
        .csr_write_o(csr_write), .ecall_o(ecall), .ebreak_o(ebreak), .mret_o(mret),
        .fence_i_o(fence_i)
    );

    imm_gen u_imm (
        .inst_i(inst), .imm_sel_i(imm_sel), .imm_o(imm)
    );

    reg_file u_regs (
        .clk(clk), .rst_n(rst_n), .rs1_i(inst.r.rs1), .rs2_i(inst.r.rs2),
        .wb_rd_i(wb_rd_i), .wb_write_i(wb_write_i), .wb_data_i(wb_data_i),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    // ------------------------------------------------------------
    // Output pipeline register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {valid_o, pc_o, rs1_data_o, rs2_data_o, imm_o, rd_o, rd_write_o, rd_sel_o} <= '0;
            {alu_op_o, alu_sub_o, alu_sra_o, alu_in1_pc_o, alu_in2_imm_o} <= '0;
            {is_branch_o, is_jal_o, is_jalr_o, is_load_o, is_store_o, word_op_o} <= '0;
            {funct3_o, csr_op_o, csr_addr_o, csr_write_o} <= '0;
            {ecall_o, ebreak_o, mret_o, fence_i_o} <= '0;
        end else if (ready_i) begin
            valid_o       <= inst_valid_i && !flush_i;   // Killed by a taken jump.
            pc_o          <= pc_i;
            rs1_data_o    <= rs1_data;
            rs2_data_o    <= rs2_data;
            imm_o         <= imm;
            rd_o          <= inst.r.rd;
            rd_write_o    <= rd_write;
            rd_sel_o      <= rd_sel;
            alu_op_o      <= alu_op;
            alu_sub_o     <= alu_sub;
            alu_sra_o     <= alu_sra;
            alu_in1_pc_o  <= alu_in1_pc;
            alu_in2_imm_o <= alu_in2_imm;
            {is_branch_o, is_jal_o, is_jalr_o} <= {is_branch, is_jal, is_jalr};
            {is_load_o, is_store_o, word_op_o} <= {is_load, is_store, word_op};
            funct3_o      <= inst.r.funct3;
            csr_op_o      <= csr_op;
            csr_addr_o    <= inst.i.imm_11_0;
            csr_write_o   <= csr_write;
            {ecall_o, ebreak_o, mret_o, fence_i_o} <= {ecall, ebreak, mret, fence_i};
        end
    end

    // A stalled stage must not drop or invent an instruction.
    a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
                                   !ready_i |=> $stable(valid_o))
        else $error("decode_stage: valid_o changed under back-pressure");

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 4 ns period.
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Synchronous reset held for 5 rising edges.
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: tests/decode_checks.svh
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

// ------------------------------------------------------------
// Compare tasks, one per kind of result
// ------------------------------------------------------------
task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
                          input logic [`XLEN-1:0] act);
    if (act !== exp) begin
        $display("ERR %s expected %h actual %h", name, exp, act);
        $display("*** FAILED ***");
        $fatal(1, "value mismatch");
    end
endtask

// ALU opcodes and the narrower select codes.
task automatic check_code(input string name, input logic [`ALU_OP_W-1:0] exp,
                          input logic [`ALU_OP_W-1:0] act);
    if (act !== exp) begin
        $display("ERR %s expected %h actual %h", name, exp, act);
        $display("*** FAILED ***");
        $fatal(1, "code mismatch");
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("ERR %s expected %b actual %b", name, exp, act);
        $display("*** FAILED ***");
        $fatal(1, "flag mismatch");
    end
endtask

task automatic check_csr_addr(input string name, input logic [11:0] exp,
                              input logic [11:0] act);
    if (act !== exp) begin
        $display("ERR %s expected %h actual %h", name, exp, act);
        $display("*** FAILED ***");
        $fatal(1, "address mismatch");
    end
endtask

`endif

// File: tests/decode_tb.sv
`timescale 1ns/1ns
`include "rv_decode_consts.svh"

module decode_tb
    import rv_decode_pkg::*;
();

    logic clk, rst_n;
    logic [31:0] inst_i;
    logic [`XLEN-1:0] pc_i, wb_data_i;
    logic inst_valid_i, ready_i, flush_i, wb_write_i;
    logic [`REG_ADDR_W-1:0] wb_rd_i;
    logic ready_o, valid_o, rd_write_o, alu_sub_o, alu_sra_o, alu_in1_pc_o, alu_in2_imm_o;
    logic is_branch_o, is_jal_o, is_jalr_o, is_load_o, is_store_o, word_op_o;
    logic csr_op_o, csr_write_o, ecall_o, ebreak_o, mret_o, fence_i_o;
    logic [`XLEN-1:0] pc_o, rs1_data_o, rs2_data_o, imm_o;
    logic [`REG_ADDR_W-1:0] rd_o;
    logic [`RD_SEL_W-1:0] rd_sel_o;
    logic [`ALU_OP_W-1:0] alu_op_o;
    logic [2:0] funct3_o;
    logic [11:0] csr_addr_o;
    int cycles;

    tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    decode_stage u_dut (.*);

    `include "decode_checks.svh"

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 2000) begin
            $display("Timeout: the tests did not finish within 2000 cycles");
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] mk_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    // Format 0..5 is I, S, B, J, U, zimm.
    function automatic logic [63:0] expect_imm(input logic [31:0] w, input int fmt);
        case (fmt)
            0: return {{52{w[31]}}, w[31:20]};
            1: return {{52{w[31]}}, w[31:25], w[11:7]};
            2: return {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            3: return {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            4: return {{32{w[31]}}, w[31:12], 12'b0};
            default: return {59'b0, w[19:15]};
        endcase
    endfunction

    // Drive one valid instruction at the falling edge, sample after the rising edge.
    task automatic issue(input logic [31:0] word, input logic we, input logic [4:0] rd,
                         input logic [63:0] data);
        @(negedge clk);
        inst_i = word;
        pc_i = pc_i + 4;
        {inst_valid_i, ready_i, flush_i} = 3'b110;
        {wb_write_i, wb_rd_i, wb_data_i} = {we, rd, data};
        @(posedge clk);
        #1;
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic test_imm();
        logic [6:0] opcs [6];
        logic [31:0] w;
        opcs = '{`OPC_LOAD, `OPC_STORE, `OPC_BRANCH, `OPC_JAL, `OPC_LUI, `OPC_SYSTEM};
        check_flag("reset_valid", 1'b0, valid_o);
        for (int fmt = 0; fmt < 6; fmt++) begin
            for (int k = 0; k < 8; k++) begin
                w = $urandom();
                w[6:0] = opcs[fmt];
                if (fmt == 5) w[14:12] = {1'b1, 2'(1 + $urandom_range(0, 2))};
                issue(w, 1'b0, 5'd0, 64'd0);
                check_word("imm", expect_imm(w, fmt), imm_o);
                check_word("pc", pc_i, pc_o);
                check_flag("valid", 1'b1, valid_o);
                check_flag("is_branch", fmt == 2, is_branch_o);
            end
        end
    endtask

    task automatic test_regs();
        logic [63:0] model [32];
        logic [63:0] d;
        for (int r = 0; r < 32; r++) begin
            d = {$urandom(), $urandom()};
            model[r] = (r == 0) ? 64'd0 : d;
            issue(32'h0000_0013, 1'b1, 5'(r), d);
        end
        for (int r = 0; r < 32; r++) begin
            issue(mk_r(7'd0, 5'(r + 1), 5'(r), 3'd0, 5'd1, `OPC_ALU_R), 1'b0, 5'd0, 64'd0);
            check_word("regs_rs1", model[r], rs1_data_o);
            check_word("regs_rs2", model[(r + 1) % 32], rs2_data_o);
        end
        d = {$urandom(), $urandom()};
        issue(mk_r(7'd0, 5'd7, 5'd7, 3'd0, 5'd1, `OPC_ALU_R), 1'b1, 5'd7, d);
        check_word("bypass_rs1", d, rs1_data_o);
        check_word("bypass_rs2", d, rs2_data_o);
        issue(mk_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd1, `OPC_ALU_R), 1'b1, 5'd0, d);
        check_word("bypass_x0", 64'd0, rs1_data_o);
    endtask

    task automatic test_alu();
        logic [6:0] opcs [4];
        logic [6:0] f7;
        logic reg_form;
        opcs = '{`OPC_ALU_R, `OPC_ALU_W, `OPC_ALU_I, `OPC_ALU_IW};
        for (int f = 0; f < 4; f++) begin
            reg_form = (f < 2);
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int v = 0; v < 3; v++) begin
                    f7 = (v == 0) ? 7'b0000000 : (v == 1) ? 7'b0100000 : 7'b0000001;
                    if (!reg_form) f7[0] = $urandom_range(0, 1);
                    issue(mk_r(f7, 5'($urandom()), 5'($urandom()), 3'(f3), 5'd3, opcs[f]),
                          1'b0, 5'd0, 64'd0);
                    check_code("alu_op", reg_form ? {f7[0], 3'(f3)} : {1'b0, 3'(f3)},
                               alu_op_o);
                    check_flag("alu_sub", reg_form && f3 == 0 && f7 == 7'b0100000, alu_sub_o);
                    check_flag("alu_sra", f3 == 5 && f7[6:1] == 6'b010000, alu_sra_o);
                    check_flag("alu_in1_pc", 1'b0, alu_in1_pc_o);
                    check_flag("alu_in2_imm", !reg_form, alu_in2_imm_o);
                    check_flag("word_op", f == 1 || f == 3, word_op_o);
                    check_code("funct3", 4'(f3), 4'(funct3_o));
                end
            end
        end
    endtask

    task automatic test_dest_sys();
        logic [6:0] opcs [6];
        logic [1:0] sels [6];
        logic [31:0] sys [4];
        logic [31:0] w;
        logic [4:0] rs1;
        opcs = '{`OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR, `OPC_LOAD, `OPC_STORE};
        sels = '{2'd2, 2'd0, 2'd1, 2'd1, 2'd0, 2'd0};
        for (int k = 0; k < 6; k++) begin
            w = $urandom();
            w[6:0] = opcs[k];
            issue(w, 1'b0, 5'd0, 64'd0);
            check_code("rd_sel", 4'(sels[k]), 4'(rd_sel_o));
            check_flag("rd_write", k != 5, rd_write_o);
            check_flag("alu_in1_pc", k == 1 || k == 2, alu_in1_pc_o);
            check_flag("is_jal", k == 2, is_jal_o);
            check_flag("is_jalr", k == 3, is_jalr_o);
            check_flag("is_load", k == 4, is_load_o);
            check_flag("is_store", k == 5, is_store_o);
            if (k != 5) begin
                check_word("rd", 64'(w[11:7]), 64'(rd_o));
            end
        end
        sys = '{`INST_ECALL, `INST_EBREAK, `INST_MRET, `INST_FENCE_I};
        for (int k = 0; k < 4; k++) begin
            issue(sys[k], 1'b0, 5'd0, 64'd0);
            check_flag("ecall", k == 0, ecall_o);
            check_flag("ebreak", k == 1, ebreak_o);
            check_flag("mret", k == 2, mret_o);
            check_flag("fence_i", k == 3, fence_i_o);
        end
        for (int f3 = 1; f3 < 4; f3++) begin
            for (int z = 0; z < 2; z++) begin
                rs1 = (z == 0) ? 5'd0 : 5'(1 + $urandom_range(0, 30));
                w = {12'($urandom()), rs1, 3'(f3), 5'(1 + $urandom_range(0, 30)), `OPC_SYSTEM};
                issue(w, 1'b0, 5'd0, 64'd0);
                check_flag("csr_write", f3 == 1 || rs1 != 0, csr_write_o);
                check_csr_addr("csr_addr", w[31:20], csr_addr_o);
                check_code("csr_rd_sel", 4'd3, 4'(rd_sel_o));
                check_flag("csr_op", 1'b1, csr_op_o);
            end
        end
    endtask

    task automatic test_handshake();
        logic [63:0] pc_hold, imm_hold;
        logic [3:0] op_hold;
        issue(mk_r(7'b0100000, 5'd2, 5'd1, 3'd0, 5'd4, `OPC_ALU_R), 1'b0, 5'd0, 64'd0);
        {pc_hold, imm_hold, op_hold} = {pc_i, 64'd0, 4'b0000};   // SUB has no immediate.
        @(negedge clk);
        ready_i = 1'b0;
        inst_i = {$urandom()};
        inst_i[6:0] = `OPC_ALU_I;
        pc_i = pc_i + 64'h100;
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            #1;
            check_flag("stall_ready", 1'b0, ready_o);
            check_flag("stall_valid", 1'b1, valid_o);
            check_word("stall_pc", pc_hold, pc_o);
            check_word("stall_imm", imm_hold, imm_o);
            check_code("stall_op", op_hold, alu_op_o);
            check_flag("stall_sub", 1'b1, alu_sub_o);
        end
        @(negedge clk);
        {ready_i, flush_i} = 2'b11;
        @(posedge clk);
        #1;
        check_flag("flush_valid", 1'b0, valid_o);
        @(negedge clk);
        {inst_valid_i, flush_i} = 2'b00;
        @(posedge clk);
        #1;
        check_flag("invalid_valid", 1'b0, valid_o);
    endtask

    initial begin
        void'($urandom(32'hef06_0222));
        cycles = 0;
        inst_i = 32'h0000_0013;
        pc_i = 64'h8000_0000;
        {inst_valid_i, ready_i, flush_i, wb_write_i} = 4'b0000;
        wb_rd_i = '0;
        wb_data_i = '0;
        @(posedge rst_n);
        @(posedge clk);
        #1;
        test_imm();
        test_regs();
        test_alu();
        test_dest_sys();
        test_handshake();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verilog
+incdir+tests
verilog/rv_decode_pkg.sv
verilog/opcode_decoder.sv
verilog/imm_gen.sv
verilog/reg_file.sv
verilog/decode_stage.sv
tests/tb_clock_gen.sv
tests/decode_tb.sv
